//--- hw/bimodal_table.sv
`timescale 1ns/10ps

module bimodal_table (
    input  logic                       clk,
    input  logic                       rst,
    // prediction port
    input  logic [bpu_pkg::xlen-1:0]   pc_i,
    output logic                       taken_o,
    // training port
    input  logic [bpu_pkg::xlen-1:0]   upd_pc_i,
    input  logic                       train_i,
    input  logic                       upd_taken_i
);

    logic [1:0]                         ctr_q [bpu_pkg::bimodal_entries];
    logic [bpu_pkg::bm_idx_width-1:0]   pred_idx;
    logic [bpu_pkg::bm_idx_width-1:0]   upd_idx;

    assign pred_idx = bpu_pkg::bimodal_index(pc_i);
    assign upd_idx = bpu_pkg::bimodal_index(upd_pc_i);

    // counter msb gives the direction
    assign taken_o = ctr_q[pred_idx][1];

    // start weakly not taken everywhere
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::bimodal_entries; i++) begin
                ctr_q[i] <= 2'd1;
            end
        end else if (train_i) begin
            ctr_q[upd_idx] <= bpu_pkg::sat_count(ctr_q[upd_idx], upd_taken_i);
        end
    end

endmodule

//--- hw/bpu_ctrl.sv
`timescale 1ns/10ps

module bpu_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    // fetch side
    input  logic [bpu_pkg::xlen-1:0]           if_pc_i,
    input  logic [bpu_pkg::xlen-1:0]           if_inst_i,
    // execute feedback
    input  logic                               ex_valid_i,
    input  logic                               ex_taken_i,
    input  logic                               ex_correct_i,
    input  bpu_pkg::provider_e                 ex_provider_i,
    // table lookups
    input  logic                               bm_taken_i,
    input  logic                               t0_match_i,
    input  logic                               t0_taken_i,
    input  logic                               t1_match_i,
    input  logic                               t1_taken_i,
    input  logic                               t0_upd_tag_hit_i,
    input  logic                               t1_upd_tag_hit_i,
    input  logic                               btb_hit_i,
    input  logic [bpu_pkg::xlen-1:0]           btb_target_i,
    // prediction
    output logic                               is_branch_o,
    output logic                               pred_taken_o,
    output logic [bpu_pkg::xlen-1:0]           pred_pc_o,
    output bpu_pkg::provider_e                 pred_provider_o,
    output logic [bpu_pkg::hist_width-1:0]     hist_o,
    // training controls
    output logic                               bm_train_o,
    output bpu_pkg::tagged_op_e                t0_op_o,
    output bpu_pkg::tagged_op_e                t1_op_o,
    output logic                               btb_fill_o
);

    bpu_pkg::opcode_e                 opcode;
    bpu_pkg::provider_e               br_provider;
    logic                             br_taken;
    logic [bpu_pkg::xlen-1:0]         seq_pc;
    logic [bpu_pkg::hist_width-1:0]   hist_q;

    assign seq_pc = if_pc_i + 32'd4;

    // major opcode decode
    always_comb begin
        case (if_inst_i[6:0])
            7'b1100011: opcode = bpu_pkg::op_branch;
            7'b1101111: opcode = bpu_pkg::op_jal;
            7'b1100111: opcode = bpu_pkg::op_jalr;
            default:    opcode = bpu_pkg::op_other;
        endcase
    end

    // longest history wins, bimodal as fallback
    always_comb begin
        if (t1_match_i) begin
            br_provider = bpu_pkg::prov_t1;
            br_taken = t1_taken_i;
        end else if (t0_match_i) begin
            br_provider = bpu_pkg::prov_t0;
            br_taken = t0_taken_i;
        end else begin
            br_provider = bpu_pkg::prov_bimodal;
            br_taken = bm_taken_i;
        end
    end

    // direction and next fetch pc
    always_comb begin
        is_branch_o = 1'b0;
        pred_taken_o = 1'b0;
        pred_pc_o = seq_pc;
        pred_provider_o = bpu_pkg::prov_bimodal;
        case (opcode)
            bpu_pkg::op_branch: begin
                is_branch_o = 1'b1;
                pred_provider_o = br_provider;
                pred_taken_o = br_taken;
                if (br_taken) begin
                    pred_pc_o = btb_hit_i ? btb_target_i : if_pc_i + bpu_pkg::b_imm(if_inst_i);
                end
            end
            bpu_pkg::op_jal: begin
                is_branch_o = 1'b1;
                pred_taken_o = 1'b1;
                pred_pc_o = btb_hit_i ? btb_target_i : if_pc_i + bpu_pkg::j_imm(if_inst_i);
            end
            // register target unknown here, falls through to pc+4
            bpu_pkg::op_jalr: begin
                is_branch_o = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // bimodal and btb train on every feedback
    assign bm_train_o = ex_valid_i;
    assign btb_fill_o = ex_valid_i && ex_taken_i;

    // tagged table training from the returned provider
    always_comb begin
        t0_op_o = bpu_pkg::top_hold;
        t1_op_o = bpu_pkg::top_hold;
        if (ex_valid_i) begin
            if (ex_correct_i) begin
                // strengthen the table that was right
                if (ex_provider_i == bpu_pkg::prov_t1) begin
                    t1_op_o = bpu_pkg::top_count;
                end else if (ex_provider_i == bpu_pkg::prov_t0) begin
                    t0_op_o = bpu_pkg::top_count;
                end
            end else if (ex_provider_i == bpu_pkg::prov_t1) begin
                t1_op_o = bpu_pkg::top_reset_strong;
            end else if (ex_provider_i == bpu_pkg::prov_t0) begin
                t0_op_o = bpu_pkg::top_reset_strong;
            end else if (ex_provider_i == bpu_pkg::prov_bimodal) begin
                // bimodal missed, claim an entry in t1 first
                if (!t1_upd_tag_hit_i) begin
                    t1_op_o = bpu_pkg::top_allocate;
                end else if (!t0_upd_tag_hit_i) begin
                    t0_op_o = bpu_pkg::top_allocate;
                end
            end
        end
    end

    // global history, newest outcome in bit 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (ex_valid_i) begin
            hist_q <= {hist_q[bpu_pkg::hist_width-2:0], ex_taken_i};
        end
    end

    assign hist_o = hist_q;

endmodule

//--- hw/bpu_pkg.sv
package bpu_pkg;

    // datapath and history sizes
    localparam int xlen = 32;
    localparam int hist_width = 16;

    // table geometry
    localparam int bimodal_entries = 512;
    localparam int tagged_entries = 256;
    localparam int tag_width = 10;
    localparam int partial_tag_bits = 6;
    localparam int btb_entries = 256;
    localparam int btb_tag_width = 22;

    // index widths follow the entry counts
    localparam int bm_idx_width = $clog2(bimodal_entries);
    localparam int tagged_idx_width = $clog2(tagged_entries);
    localparam int btb_idx_width = $clog2(btb_entries);

    // instruction class from the major opcode
    typedef enum logic [1:0] {
        op_branch,
        op_jal,
        op_jalr,
        op_other
    } opcode_e;

    // component that supplied the direction
    typedef enum logic [1:0] {
        prov_bimodal,
        prov_t0,
        prov_t1
    } provider_e;

    // selects the hash variant of a tagged table
    typedef enum logic {
        tbl_t0,
        tbl_t1
    } table_id_e;

    // training operation for one tagged table
    typedef enum logic [2:0] {
        top_hold,
        top_count,
        top_reset_strong,
        top_allocate
    } tagged_op_e;

    // pc low bits folded with short or long history
    function automatic logic [tagged_idx_width-1:0] tagged_index(
        input table_id_e id,
        input logic [xlen-1:0] pc,
        input logic [hist_width-1:0] hist
    );
        if (id == tbl_t0) begin
            return pc[7:0] ^ hist[7:0];
        end
        return pc[7:0] ^ hist[15:8];
    endfunction

    // t1 tag only mixes in the low history byte
    function automatic logic [tag_width-1:0] tagged_tag(
        input table_id_e id,
        input logic [xlen-1:0] pc,
        input logic [hist_width-1:0] hist
    );
        if (id == tbl_t0) begin
            return pc[17:8] ^ hist[15:6];
        end
        return pc[17:8] ^ {{(tag_width - 8){1'b0}}, hist[7:0]};
    endfunction

    function automatic logic [bm_idx_width-1:0] bimodal_index(input logic [xlen-1:0] pc);
        return pc[9:1];
    endfunction

    function automatic logic [btb_idx_width-1:0] btb_index(input logic [xlen-1:0] pc);
        return pc[9:2];
    endfunction

    function automatic logic [btb_tag_width-1:0] btb_tag(input logic [xlen-1:0] pc);
        return pc[31:10];
    endfunction

    // sign-extended conditional branch offset
    function automatic logic [xlen-1:0] b_imm(input logic [xlen-1:0] inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    // sign-extended jal offset
    function automatic logic [xlen-1:0] j_imm(input logic [xlen-1:0] inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // two-bit counter step, saturating at 0 and 3
    function automatic logic [1:0] sat_count(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == 2'd3) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'd0) ? ctr : ctr - 2'd1;
    endfunction

endpackage

//--- hw/bpu_top.sv
`timescale 1ns/10ps

module bpu_top (
    input  logic                               clk,
    input  logic                               rst,
    // fetched instruction
    input  logic [bpu_pkg::xlen-1:0]           if_pc_i,
    input  logic [bpu_pkg::xlen-1:0]           if_inst_i,
    // execute feedback
    input  logic                               ex_valid_i,
    input  logic                               ex_taken_i,
    input  logic                               ex_correct_i,
    input  logic [bpu_pkg::xlen-1:0]           ex_pc_i,
    input  logic [bpu_pkg::hist_width-1:0]     ex_hist_i,
    input  bpu_pkg::provider_e                 ex_provider_i,
    input  logic [bpu_pkg::xlen-1:0]           ex_target_i,
    // prediction
    output logic                               is_branch_o,
    output logic                               pred_taken_o,
    output logic [bpu_pkg::xlen-1:0]           pred_pc_o,
    output bpu_pkg::provider_e                 pred_provider_o,
    output logic [bpu_pkg::hist_width-1:0]     hist_o
);

    logic                       bm_taken;
    logic                       bm_train;
    logic                       t0_match;
    logic                       t0_taken;
    logic                       t0_upd_tag_hit;
    logic                       t1_match;
    logic                       t1_taken;
    logic                       t1_upd_tag_hit;
    logic                       btb_hit;
    logic [bpu_pkg::xlen-1:0]   btb_target;
    logic                       btb_fill;
    bpu_pkg::tagged_op_e        t0_op;
    bpu_pkg::tagged_op_e        t1_op;

    bpu_ctrl i_ctrl (
        .clk              (clk),
        .rst              (rst),
        .if_pc_i          (if_pc_i),
        .if_inst_i        (if_inst_i),
        .ex_valid_i       (ex_valid_i),
        .ex_taken_i       (ex_taken_i),
        .ex_correct_i     (ex_correct_i),
        .ex_provider_i    (ex_provider_i),
        .bm_taken_i       (bm_taken),
        .t0_match_i       (t0_match),
        .t0_taken_i       (t0_taken),
        .t1_match_i       (t1_match),
        .t1_taken_i       (t1_taken),
        .t0_upd_tag_hit_i (t0_upd_tag_hit),
        .t1_upd_tag_hit_i (t1_upd_tag_hit),
        .btb_hit_i        (btb_hit),
        .btb_target_i     (btb_target),
        .is_branch_o      (is_branch_o),
        .pred_taken_o     (pred_taken_o),
        .pred_pc_o        (pred_pc_o),
        .pred_provider_o  (pred_provider_o),
        .hist_o           (hist_o),
        .bm_train_o       (bm_train),
        .t0_op_o          (t0_op),
        .t1_op_o          (t1_op),
        .btb_fill_o       (btb_fill)
    );

    bimodal_table i_bimodal (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (if_pc_i),
        .taken_o     (bm_taken),
        .upd_pc_i    (ex_pc_i),
        .train_i     (bm_train),
        .upd_taken_i (ex_taken_i)
    );

    // short history table
    tagged_table #(
        .table_id (bpu_pkg::tbl_t0)
    ) i_t0 (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (if_pc_i),
        .hist_i        (hist_o),
        .match_o       (t0_match),
        .taken_o       (t0_taken),
        .upd_pc_i      (ex_pc_i),
        .upd_hist_i    (ex_hist_i),
        .upd_tag_hit_o (t0_upd_tag_hit),
        .op_i          (t0_op),
        .upd_taken_i   (ex_taken_i)
    );

    // long history table
    tagged_table #(
        .table_id (bpu_pkg::tbl_t1)
    ) i_t1 (
        .clk           (clk),
        .rst           (rst),
        .pc_i          (if_pc_i),
        .hist_i        (hist_o),
        .match_o       (t1_match),
        .taken_o       (t1_taken),
        .upd_pc_i      (ex_pc_i),
        .upd_hist_i    (ex_hist_i),
        .upd_tag_hit_o (t1_upd_tag_hit),
        .op_i          (t1_op),
        .upd_taken_i   (ex_taken_i)
    );

    btb i_btb (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (if_pc_i),
        .hit_o        (btb_hit),
        .target_o     (btb_target),
        .upd_pc_i     (ex_pc_i),
        .fill_i       (btb_fill),
        .upd_target_i (ex_target_i)
    );

endmodule

//--- hw/btb.sv
`timescale 1ns/10ps

module btb (
    input  logic                       clk,
    input  logic                       rst,
    // lookup port
    input  logic [bpu_pkg::xlen-1:0]   pc_i,
    output logic                       hit_o,
    output logic [bpu_pkg::xlen-1:0]   target_o,
    // fill port
    input  logic [bpu_pkg::xlen-1:0]   upd_pc_i,
    input  logic                       fill_i,
    input  logic [bpu_pkg::xlen-1:0]   upd_target_i
);

    logic [bpu_pkg::btb_tag_width-1:0]   tag_mem [bpu_pkg::btb_entries];
    logic [bpu_pkg::xlen-1:0]            target_mem [bpu_pkg::btb_entries];
    logic [bpu_pkg::btb_entries-1:0]     valid_q;
    logic [bpu_pkg::btb_idx_width-1:0]   pred_idx;
    logic [bpu_pkg::btb_idx_width-1:0]   upd_idx;

    assign pred_idx = bpu_pkg::btb_index(pc_i);
    assign upd_idx = bpu_pkg::btb_index(upd_pc_i);

    // direct mapped, one way
    assign hit_o = valid_q[pred_idx] && (tag_mem[pred_idx] == bpu_pkg::btb_tag(pc_i));
    assign target_o = target_mem[pred_idx];

    // only the valid bits are cleared
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // tag and target overwrite the old entry
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_mem[upd_idx] <= bpu_pkg::btb_tag(upd_pc_i);
            target_mem[upd_idx] <= upd_target_i;
        end
    end

endmodule

//--- hw/tagged_table.sv
`timescale 1ns/10ps

module tagged_table #(
    parameter bpu_pkg::table_id_e table_id = bpu_pkg::tbl_t0
) (
    input  logic                               clk,
    input  logic                               rst,
    // prediction port
    input  logic [bpu_pkg::xlen-1:0]           pc_i,
    input  logic [bpu_pkg::hist_width-1:0]     hist_i,
    output logic                               match_o,
    output logic                               taken_o,
    // training port
    input  logic [bpu_pkg::xlen-1:0]           upd_pc_i,
    input  logic [bpu_pkg::hist_width-1:0]     upd_hist_i,
    output logic                               upd_tag_hit_o,
    input  bpu_pkg::tagged_op_e                op_i,
    input  logic                               upd_taken_i
);

    logic [bpu_pkg::tag_width-1:0]          tag_q [bpu_pkg::tagged_entries];
    logic [1:0]                             ctr_q [bpu_pkg::tagged_entries];
    logic [bpu_pkg::tagged_idx_width-1:0]   pred_idx;
    logic [bpu_pkg::tagged_idx_width-1:0]   upd_idx;
    logic [bpu_pkg::tag_width-1:0]          pred_tag;
    logic [bpu_pkg::tag_width-1:0]          upd_tag;

    // same hash variant on both ports
    assign pred_idx = bpu_pkg::tagged_index(table_id, pc_i, hist_i);
    assign pred_tag = bpu_pkg::tagged_tag(table_id, pc_i, hist_i);
    assign upd_idx = bpu_pkg::tagged_index(table_id, upd_pc_i, upd_hist_i);
    assign upd_tag = bpu_pkg::tagged_tag(table_id, upd_pc_i, upd_hist_i);

    // prediction only compares the upper tag bits
    assign match_o = tag_q[pred_idx][bpu_pkg::tag_width-1 -: bpu_pkg::partial_tag_bits]
                  == pred_tag[bpu_pkg::tag_width-1 -: bpu_pkg::partial_tag_bits];
    assign taken_o = ctr_q[pred_idx][1];

    // allocation decision needs the whole tag
    assign upd_tag_hit_o = (tag_q[upd_idx] == upd_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < bpu_pkg::tagged_entries; i++) begin
                tag_q[i] <= '0;
                ctr_q[i] <= 2'd1;
            end
        end else begin
            case (op_i)
                bpu_pkg::top_count: begin
                    ctr_q[upd_idx] <= bpu_pkg::sat_count(ctr_q[upd_idx], upd_taken_i);
                end
                // jump to the strong state of the real outcome
                bpu_pkg::top_reset_strong: begin
                    ctr_q[upd_idx] <= upd_taken_i ? 2'd3 : 2'd0;
                end
                // new entry starts weak toward the outcome
                bpu_pkg::top_allocate: begin
                    tag_q[upd_idx] <= upd_tag;
                    ctr_q[upd_idx] <= upd_taken_i ? 2'd2 : 2'd1;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --top-module bpu_tb -f sources.f -o bpu_sim \
    && ./obj_dir/bpu_sim | tee sim.log \
    && grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- sources.f
+incdir+tb
hw/bpu_pkg.sv
hw/bimodal_table.sv
hw/tagged_table.sv
hw/btb.sv
hw/bpu_ctrl.sv
hw/bpu_top.sv
tb/bpu_tb.sv

//--- tb/bpu_ref_model.svh
// reference copies of the predictor state
logic [1:0]  bm_ctr      [bpu_pkg::bimodal_entries];
logic [9:0]  tg_tag      [2][bpu_pkg::tagged_entries];
logic [1:0]  tg_ctr      [2][bpu_pkg::tagged_entries];
logic        btb_valid   [bpu_pkg::btb_entries];
logic [21:0] btb_tags    [bpu_pkg::btb_entries];
logic [31:0] btb_targets [bpu_pkg::btb_entries];
logic [15:0] model_hist;

// table 0 folds the low history byte, table 1 the high byte
function automatic logic [7:0] fold_index(input int t, input logic [31:0] pc,
                                          input logic [15:0] h);
    logic [7:0] fold;
    fold = (t == 0) ? h[7:0] : h[15:8];
    return pc[7:0] ^ fold;
endfunction

function automatic logic [9:0] fold_tag(input int t, input logic [31:0] pc,
                                        input logic [15:0] h);
    logic [9:0] mix;
    mix = (t == 0) ? h[15:6] : {2'b00, h[7:0]};
    return pc[17:8] ^ mix;
endfunction

// b-type offset, 13 bits before extension
function automatic logic [31:0] branch_offset(input logic [31:0] inst);
    logic [12:0] off;
    off = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    return {{19{off[12]}}, off};
endfunction

// j-type offset, 21 bits before extension
function automatic logic [31:0] jump_offset(input logic [31:0] inst);
    logic [20:0] off;
    off = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    return {{11{off[20]}}, off};
endfunction

function automatic logic [1:0] next_counter(input logic [1:0] c, input logic up);
    if (up && c != 2'd3) begin
        return c + 2'd1;
    end
    if (!up && c != 2'd0) begin
        return c - 2'd1;
    end
    return c;
endfunction

task automatic reset_model();
    for (int i = 0; i < bpu_pkg::bimodal_entries; i++) begin
        bm_ctr[i] = 2'd1;
    end
    for (int i = 0; i < bpu_pkg::tagged_entries; i++) begin
        for (int t = 0; t < 2; t++) begin
            tg_tag[t][i] = '0;
            tg_ctr[t][i] = 2'd1;
        end
    end
    for (int i = 0; i < bpu_pkg::btb_entries; i++) begin
        btb_valid[i] = 1'b0;
        btb_tags[i] = '0;
        btb_targets[i] = '0;
    end
    model_hist = '0;
endtask

// expected outputs for one fetched instruction
task automatic predict_outputs(
    input  logic [31:0]        pc,
    input  logic [31:0]        inst,
    output logic               br,
    output logic               tk,
    output logic [31:0]        npc,
    output bpu_pkg::provider_e prov
);
    logic [7:0] i0;
    logic [7:0] i1;
    logic [7:0] bi;
    logic [9:0] g0;
    logic [9:0] g1;
    logic       hit;
    i0 = fold_index(0, pc, model_hist);
    i1 = fold_index(1, pc, model_hist);
    g0 = fold_tag(0, pc, model_hist);
    g1 = fold_tag(1, pc, model_hist);
    bi = pc[9:2];
    hit = btb_valid[bi] && (btb_tags[bi] == pc[31:10]);
    br = 1'b0;
    tk = 1'b0;
    npc = pc + 32'd4;
    prov = bpu_pkg::prov_bimodal;
    case (inst[6:0])
        7'b1100011: begin
            br = 1'b1;
            // upper six tag bits decide a match, t1 first
            if (tg_tag[1][i1][9:4] == g1[9:4]) begin
                prov = bpu_pkg::prov_t1;
                tk = tg_ctr[1][i1][1];
            end else if (tg_tag[0][i0][9:4] == g0[9:4]) begin
                prov = bpu_pkg::prov_t0;
                tk = tg_ctr[0][i0][1];
            end else begin
                tk = bm_ctr[pc[9:1]][1];
            end
            if (tk) begin
                npc = hit ? btb_targets[bi] : pc + branch_offset(inst);
            end
        end
        7'b1101111: begin
            br = 1'b1;
            tk = 1'b1;
            npc = hit ? btb_targets[bi] : pc + jump_offset(inst);
        end
        7'b1100111: begin
            br = 1'b1;
        end
        default: begin
        end
    endcase
endtask

// one execute feedback, state as it was before the edge
task automatic apply_feedback(
    input logic [31:0]        pc,
    input logic [15:0]        h,
    input bpu_pkg::provider_e prov,
    input logic               taken,
    input logic               correct,
    input logic [31:0]        tgt
);
    logic [7:0] i0;
    logic [7:0] i1;
    logic [9:0] g0;
    logic [9:0] g1;
    logic       hit0;
    logic       hit1;
    i0 = fold_index(0, pc, h);
    i1 = fold_index(1, pc, h);
    g0 = fold_tag(0, pc, h);
    g1 = fold_tag(1, pc, h);
    hit0 = (tg_tag[0][i0] == g0);
    hit1 = (tg_tag[1][i1] == g1);
    bm_ctr[pc[9:1]] = next_counter(bm_ctr[pc[9:1]], taken);
    if (taken) begin
        btb_valid[pc[9:2]] = 1'b1;
        btb_tags[pc[9:2]] = pc[31:10];
        btb_targets[pc[9:2]] = tgt;
    end
    if (correct) begin
        if (prov == bpu_pkg::prov_t1) begin
            tg_ctr[1][i1] = next_counter(tg_ctr[1][i1], taken);
        end else if (prov == bpu_pkg::prov_t0) begin
            tg_ctr[0][i0] = next_counter(tg_ctr[0][i0], taken);
        end
    end else if (prov == bpu_pkg::prov_t1) begin
        tg_ctr[1][i1] = taken ? 2'd3 : 2'd0;
    end else if (prov == bpu_pkg::prov_t0) begin
        tg_ctr[0][i0] = taken ? 2'd3 : 2'd0;
    end else if (!hit1) begin
        tg_tag[1][i1] = g1;
        tg_ctr[1][i1] = taken ? 2'd2 : 2'd1;
    end else if (!hit0) begin
        tg_tag[0][i0] = g0;
        tg_ctr[0][i0] = taken ? 2'd2 : 2'd1;
    end
    model_hist = {model_hist[14:0], taken};
endtask

//--- tb/bpu_tb.sv
`timescale 1ns/10ps

module bpu_tb;

    localparam int random_cycles = 3000;
    localparam int directed_cycles = 500;
    localparam int total_cycles = 3 + directed_cycles + random_cycles;

    // one pending execute result
    typedef struct packed {
        logic [31:0]        pc;
        logic [15:0]        hist;
        bpu_pkg::provider_e prov;
        logic               taken;
        logic               correct;
        logic [31:0]        target;
        int                 due;
    } fb_t;

    logic                       clk;
    logic                       rst;
    logic [31:0]                if_pc_i;
    logic [31:0]                if_inst_i;
    logic                       ex_valid_i;
    logic                       ex_taken_i;
    logic                       ex_correct_i;
    logic [31:0]                ex_pc_i;
    logic [15:0]                ex_hist_i;
    bpu_pkg::provider_e         ex_provider_i;
    logic [31:0]                ex_target_i;
    logic                       is_branch_o;
    logic                       pred_taken_o;
    logic [31:0]                pred_pc_o;
    bpu_pkg::provider_e         pred_provider_o;
    logic [15:0]                hist_o;

    int  seed;
    int  cycle;
    fb_t pending[$];

    `include "bpu_ref_model.svh"

    bpu_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .if_pc_i         (if_pc_i),
        .if_inst_i       (if_inst_i),
        .ex_valid_i      (ex_valid_i),
        .ex_taken_i      (ex_taken_i),
        .ex_correct_i    (ex_correct_i),
        .ex_pc_i         (ex_pc_i),
        .ex_hist_i       (ex_hist_i),
        .ex_provider_i   (ex_provider_i),
        .ex_target_i     (ex_target_i),
        .is_branch_o     (is_branch_o),
        .pred_taken_o    (pred_taken_o),
        .pred_pc_o       (pred_pc_o),
        .pred_provider_o (pred_provider_o),
        .hist_o          (hist_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit from the total cycle count
    initial begin
        #(total_cycles * 4 * 2);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "check failed");
        end
    endtask

    // two regions so some pcs match reset tags and some never do
    function automatic logic [31:0] pool_pc(input logic [3:0] idx);
        return (idx[3] ? 32'h0003_1000 : 32'h0000_0200) + {24'b0, idx[2:0], 5'b0};
    endfunction

    function automatic logic [31:0] make_inst(input logic [1:0] kind, input logic [31:0] bits);
        logic [6:0] opc;
        case (kind)
            2'd0: opc = 7'b1100011;
            2'd1: opc = 7'b1101111;
            2'd2: opc = 7'b1100111;
            default: opc = bits[7] ? 7'b0110011 : 7'b0010011;
        endcase
        return {bits[31:7], opc};
    endfunction

    // one fetch cycle with model training, feedback, checks and queueing
    task automatic run_cycle(input logic [31:0] pc, input logic [31:0] inst,
                             input logic outcome, input string name);
        logic [31:0]        r;
        int                 pick;
        fb_t                fb;
        logic               e_br;
        logic               e_tk;
        logic [31:0]        e_pc;
        bpu_pkg::provider_e e_prov;
        @(posedge clk);
        cycle++;
        if (ex_valid_i) begin
            apply_feedback(ex_pc_i, ex_hist_i, ex_provider_i, ex_taken_i, ex_correct_i,
                           ex_target_i);
        end
        #1;
        // oldest entry that is due goes back first
        pick = -1;
        foreach (pending[i]) begin
            if (pick < 0 && pending[i].due <= cycle) begin
                pick = i;
            end
        end
        ex_valid_i = 1'b0;
        if (pick >= 0) begin
            fb = pending[pick];
            pending.delete(pick);
            ex_valid_i = 1'b1;
            ex_pc_i = fb.pc;
            ex_hist_i = fb.hist;
            ex_provider_i = fb.prov;
            ex_taken_i = fb.taken;
            ex_correct_i = fb.correct;
            ex_target_i = fb.target;
        end
        if_pc_i = pc;
        if_inst_i = inst;
        #1;
        predict_outputs(pc, inst, e_br, e_tk, e_pc, e_prov);
        check_value({name, " is_branch"}, 32'(e_br), 32'(is_branch_o));
        check_value({name, " taken"}, 32'(e_tk), 32'(pred_taken_o));
        check_value({name, " pred_pc"}, e_pc, pred_pc_o);
        check_value({name, " provider"}, 32'(e_prov), 32'(pred_provider_o));
        check_value({name, " hist"}, 32'(model_hist), 32'(hist_o));
        if (e_br) begin
            r = $random(seed);
            fb.pc = pc;
            fb.hist = hist_o;
            fb.prov = pred_provider_o;
            fb.taken = outcome;
            fb.correct = (pred_taken_o == outcome);
            fb.target = r[4] ? pred_pc_o : {r[31:5], 5'b0};
            fb.due = cycle + 1 + int'(r[1:0]);
            pending.push_back(fb);
        end
    endtask

    // idle until every feedback has been trained
    task automatic drain_feedback();
        int n;
        n = 0;
        while (pending.size() > 0 && n < 64) begin
            run_cycle(32'h0000_0100, 32'h0000_0013, 1'b0, "drain");
            n++;
        end
        run_cycle(32'h0000_0100, 32'h0000_0013, 1'b0, "drain");
    endtask

    // sixteen not-taken outcomes bring the history to zero
    task automatic clear_history();
        for (int n = 0; n < 16; n++) begin
            run_cycle(32'h0003_1380, make_inst(2'd0, 32'h0040_0f00), 1'b0, "clear_hist");
        end
        drain_feedback();
        check_value("clear_hist zero", 32'd0, 32'(hist_o));
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] bits;
        logic [3:0]  idx;
        logic [1:0]  kind;
        logic        taken;
        seed = 93868;
        cycle = 0;
        rst = 1'b1;
        if_pc_i = '0;
        if_inst_i = '0;
        ex_valid_i = 1'b0;
        ex_taken_i = 1'b0;
        ex_correct_i = 1'b0;
        ex_pc_i = '0;
        ex_hist_i = '0;
        ex_provider_i = bpu_pkg::prov_bimodal;
        ex_target_i = '0;
        reset_model();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // plain instructions right after reset
        check_value("reset hist", 32'd0, 32'(hist_o));
        for (int n = 0; n < 4; n++) begin
            run_cycle(pool_pc(4'(n)), make_inst(2'd3, 32'h1234_5000), 1'b0, "reset_other");
        end

        // jal from immediate, then from the filled btb over a new offset
        run_cycle(32'h0003_1040, make_inst(2'd1, 32'h0080_0000), 1'b1, "jal_imm");
        drain_feedback();
        run_cycle(32'h0003_1040, make_inst(2'd1, 32'h0100_0000), 1'b1, "jal_btb");
        drain_feedback();

        // bimodal counter walks toward taken
        for (int n = 0; n < 4; n++) begin
            run_cycle(32'h0003_1100, make_inst(2'd0, 32'h0200_0400), 1'b1, "bimodal");
            drain_feedback();
        end

        // two bimodal misses in flight, t1 allocates then t0
        clear_history();
        run_cycle(32'h0003_1204, make_inst(2'd0, 32'h0100_0200), 1'b1, "tagged_alloc");
        run_cycle(32'h0003_1204, make_inst(2'd0, 32'h0100_0200), 1'b1, "tagged_alloc");
        drain_feedback();
        clear_history();
        run_cycle(32'h0003_1204, make_inst(2'd0, 32'h0100_0200), 1'b1, "tagged_hit");
        drain_feedback();
        // same t1 entry and bimodal slot, but the btb tag misses
        run_cycle(32'h0003_1604, make_inst(2'd0, 32'h0100_0200), 1'b0, "branch_imm");
        drain_feedback();
        // t1 now strong not taken while bimodal still leans taken
        run_cycle(32'h0003_1204, make_inst(2'd0, 32'h0100_0200), 1'b0, "tagged_strong");
        drain_feedback();

        // mixed kinds with per-pc taken bias
        for (int n = 0; n < random_cycles; n++) begin
            r = $random(seed);
            bits = $random(seed);
            idx = r[3:0];
            kind = r[5:4];
            case (kind)
                2'd0: taken = (r[12:10] < idx[2:0]);
                2'd3: taken = 1'b0;
                default: taken = 1'b1;
            endcase
            run_cycle(pool_pc(idx), make_inst(kind, bits), taken, "random");
        end
        drain_feedback();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
